//--- src/cpuIsaPkg.sv
`default_nettype none

package cpuIsaPkg;

  // Register operand fields of an opcode byte
  typedef struct packed {
    logic [1:0] group;
    logic [2:0] dst;
    logic [2:0] src;
  } opcodeFields;

  typedef union packed {
    logic [7:0]  raw;   // Flow lookup
    opcodeFields f;
  } opcodeWord;

  typedef logic [2:0] regCode;

  localparam regCode regB = 3'd0;
  localparam regCode regC = 3'd1;
  localparam regCode regD = 3'd2;
  localparam regCode regE = 3'd3;
  localparam regCode regH = 3'd4;
  localparam regCode regL = 3'd5;
  localparam regCode regA = 3'd7;

  localparam int flagZ = 7;
  localparam int flagN = 6;
  localparam int flagH = 5;
  localparam int flagC = 4;

  localparam logic [7:0] flagsResetValue = 8'hB0;
  localparam logic [7:0] highPage = 8'hFF;

  localparam logic [15:0] vector0 = 16'h0040;
  localparam logic [15:0] vector1 = 16'h0048;
  localparam logic [15:0] vector2 = 16'h0050;
  localparam logic [15:0] vector3 = 16'h0060;

  typedef enum logic [2:0] {aluPass, aluAdd, aluSub, aluAnd, aluXor, aluOr} aluOp;

endpackage

`default_nettype wire

//--- src/microcodePkg.sv
`default_nettype none

package microcodePkg;

  // cmd[13:10] eof[9:7] incPc[6] bus[5] operandSel[4:0]
  typedef logic [13:0] uopWord;
  typedef logic        incPc;
  typedef logic [5:0]  flowIdx;

  typedef enum logic [3:0] {
    cmdNop, cmdRead, cmdDispatch, cmdLoadReg, cmdTmpLo, cmdTmpHi,
    cmdRegOp, cmdWriteHigh, cmdJump, cmdIntJump, cmdSetIme, cmdClearIme
  } uCmd;

  typedef enum logic [2:0] {eofNone, eofAlways, eofIfZ, eofIfNZ, eofIfC, eofIfNC} eofCond;

  localparam int incPcBit = 6;
  localparam int busBit = 5;

  // Operand select, bit 4 picks the opcode dst field, bit 3 the high page address
  localparam logic [4:0] opdDst = 5'b10000;
  localparam logic [4:0] opdA = 5'b00111;
  localparam logic [4:0] opdHigh = 5'b01000;

  localparam flowIdx flowFetch = 6'd0;
  localparam flowIdx flowInterrupt = 6'd2;
  localparam flowIdx flowNop = 6'd3;
  localparam flowIdx flowLdImm = 6'd4;
  localparam flowIdx flowLdReg = 6'd6;
  localparam flowIdx flowAlu = 6'd7;
  localparam flowIdx flowJp = 6'd8;    // JP flows on 8-entry blocks
  localparam flowIdx flowJpZ = 6'd16;
  localparam flowIdx flowJpNz = 6'd24;
  localparam flowIdx flowJpC = 6'd32;
  localparam flowIdx flowJpNc = 6'd40;
  localparam flowIdx flowLdh = 6'd48;
  localparam flowIdx flowEi = 6'd51;
  localparam flowIdx flowDi = 6'd52;

endpackage

`default_nettype wire

//--- src/busPort.sv
`timescale 1ns/1ps
`default_nettype none

module busPort
(
  input  wire logic        iClock,
  input  wire logic        reset,
  input  wire logic        start,
  input  wire logic        writeKind,
  input  wire logic [15:0] addr,
  input  wire logic [7:0]  writeData,
  output logic             memReq,
  output logic             memWrite,
  output logic [15:0]      memAddr,
  output logic [7:0]       memWriteData,
  input  wire logic        memAck,
  input  wire logic [7:0]  memReadData,
  output logic             busDone,
  output logic [7:0]       readData
);

  typedef enum logic [1:0] {idle, request, waitRelease} busState;
  busState state;

  always_ff @(posedge iClock)
  begin
    if (reset)
    begin
      state <= idle;
      memReq <= 1'b0;
      memWrite <= 1'b0;
      busDone <= 1'b0;
    end
    else
    begin
      busDone <= 1'b0;
      case (state)
        idle:
          if (start)
          begin
            memReq <= 1'b1;
            memWrite <= writeKind;
            state <= request;
          end
        request:
          if (memAck)
          begin
            memReq <= 1'b0;
            state <= waitRelease;
          end
        default:
          if (!memAck)   // Wait for the ack to drop
          begin
            memWrite <= 1'b0;
            busDone <= 1'b1;
            state <= idle;
          end
      endcase
    end
  end

  // Payload held stable through the transfer
  always_ff @(posedge iClock)
  begin
    if (state == idle && start)
    begin
      memAddr <= addr;
      memWriteData <= writeData;
    end
    if (state == request && memAck)
      readData <= memReadData;
  end

endmodule

`default_nettype wire

//--- src/interruptController.sv
`timescale 1ns/1ps
`default_nettype none

module interruptController
(
  input  wire logic             iClock,
  input  wire logic             reset,
  input  wire logic [3:0]       irq,
  input  microcodePkg::uCmd     cmd,
  output logic                  intPending,
  output logic [15:0]           vector
);

  logic [3:0] latched;
  logic       ime;

  always_ff @(posedge iClock)
  begin
    if (reset)
    begin
      latched <= '0;
      ime <= 1'b0;
    end
    else if (cmd == microcodePkg::cmdIntJump)
    begin
      latched <= '0;
      ime <= 1'b0;
    end
    else
    begin
      latched <= latched | irq;   // Sticky
      if (cmd == microcodePkg::cmdSetIme)
        ime <= 1'b1;
      else if (cmd == microcodePkg::cmdClearIme)
        ime <= 1'b0;
    end
  end

  assign intPending = ime && (latched != 4'b0);

  // Lowest set bit wins
  always_comb
  begin
    casez (latched)
      4'b???1: vector = cpuIsaPkg::vector0;
      4'b??10: vector = cpuIsaPkg::vector1;
      4'b?100: vector = cpuIsaPkg::vector2;
      default: vector = cpuIsaPkg::vector3;
    endcase
  end

endmodule

`default_nettype wire

//--- src/microcodeRom.sv
`timescale 1ns/1ps
`default_nettype none

module microcodeRom
(
  input  microcodePkg::flowIdx    uPc,
  input  cpuIsaPkg::opcodeWord    opcode,
  output microcodePkg::uopWord    uop,
  output microcodePkg::flowIdx    opFlow
);

  function automatic microcodePkg::uopWord mk(microcodePkg::uCmd c,
      microcodePkg::eofCond e, microcodePkg::incPc inc, logic bus, logic [4:0] opd);
    return {c, e, inc, bus, opd};
  endfunction

  microcodePkg::eofCond jpCond;

  // ----------------------------------------------------------------------
  // Micro-op flows
  always_comb
  begin
    case (uPc[5:3])
      3'd2: jpCond = microcodePkg::eofIfNZ;   // JP Z not taken
      3'd3: jpCond = microcodePkg::eofIfZ;
      3'd4: jpCond = microcodePkg::eofIfNC;
      3'd5: jpCond = microcodePkg::eofIfC;
      default: jpCond = microcodePkg::eofNone;
    endcase

    uop = mk(microcodePkg::cmdNop, microcodePkg::eofAlways, 1'b0, 1'b0, 5'd0);
    if (uPc >= microcodePkg::flowJp && uPc < microcodePkg::flowLdh)
    begin
      case (uPc[2:0])
        3'd0, 3'd2: uop = mk(microcodePkg::cmdRead, microcodePkg::eofNone, 1'b1, 1'b1,
                             5'd0);
        3'd1: uop = mk(microcodePkg::cmdTmpLo, microcodePkg::eofNone, 1'b0, 1'b0, 5'd0);
        3'd3: uop = mk(microcodePkg::cmdTmpHi, jpCond, 1'b0, 1'b0, 5'd0);
        default: uop = mk(microcodePkg::cmdJump, microcodePkg::eofAlways, 1'b0, 1'b0, 5'd0);
      endcase
    end
    else
    begin
      case (uPc)
        6'd0, 6'd4, 6'd48: uop = mk(microcodePkg::cmdRead, microcodePkg::eofNone, 1'b1, 1'b1,
                                    5'd0);
        6'd1: uop = mk(microcodePkg::cmdDispatch, microcodePkg::eofNone, 1'b0, 1'b0, 5'd0);
        6'd2: uop = mk(microcodePkg::cmdIntJump, microcodePkg::eofAlways, 1'b0, 1'b0, 5'd0);
        6'd5: uop = mk(microcodePkg::cmdLoadReg, microcodePkg::eofAlways, 1'b0, 1'b0,
                       microcodePkg::opdDst);
        6'd6: uop = mk(microcodePkg::cmdRegOp, microcodePkg::eofAlways, 1'b0, 1'b0,
                       microcodePkg::opdDst);
        6'd7: uop = mk(microcodePkg::cmdRegOp, microcodePkg::eofAlways, 1'b0, 1'b0,
                       microcodePkg::opdA);
        6'd49: uop = mk(microcodePkg::cmdTmpLo, microcodePkg::eofNone, 1'b0, 1'b0, 5'd0);
        6'd50: uop = mk(microcodePkg::cmdWriteHigh, microcodePkg::eofAlways, 1'b0, 1'b1,
                        microcodePkg::opdHigh);
        6'd51: uop = mk(microcodePkg::cmdSetIme, microcodePkg::eofAlways, 1'b0, 1'b0, 5'd0);
        6'd52: uop = mk(microcodePkg::cmdClearIme, microcodePkg::eofAlways, 1'b0, 1'b0, 5'd0);
        default: ;   // NOP flow
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Opcode to flow
  always_comb
  begin
    opFlow = microcodePkg::flowNop;
    case (opcode.raw)
      8'hC3: opFlow = microcodePkg::flowJp;
      8'hCA: opFlow = microcodePkg::flowJpZ;
      8'hC2: opFlow = microcodePkg::flowJpNz;
      8'hDA: opFlow = microcodePkg::flowJpC;
      8'hD2: opFlow = microcodePkg::flowJpNc;
      8'hE0: opFlow = microcodePkg::flowLdh;
      8'hFB: opFlow = microcodePkg::flowEi;
      8'hF3: opFlow = microcodePkg::flowDi;
      default:
        if (opcode.f.group == 2'b00 && opcode.f.src == 3'd6 && opcode.f.dst != 3'd6)
          opFlow = microcodePkg::flowLdImm;
        else if (opcode.f.group == 2'b01 && opcode.f.src != 3'd6 && opcode.f.dst != 3'd6)
          opFlow = microcodePkg::flowLdReg;
        else if (opcode.f.group == 2'b10 && opcode.f.src != 3'd6 &&
                 opcode.f.dst inside {3'd0, 3'd2, 3'd4, 3'd5, 3'd6})
          opFlow = microcodePkg::flowAlu;
    endcase
  end

endmodule

`default_nettype wire

//--- src/microSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module microSequencer
(
  input  wire logic              iClock,
  input  wire logic              reset,
  input  microcodePkg::flowIdx   opFlow,
  input  microcodePkg::uopWord   uop,
  input  wire logic              intPending,
  input  wire logic              busDone,
  input  wire logic              flagsZ,
  input  wire logic              flagsC,
  output microcodePkg::flowIdx   uPc,
  output microcodePkg::uCmd      cmd,
  output logic [4:0]             operandSel,
  output logic                   pcStep,
  output logic                   busStart,
  output logic                   busWriteKind,
  output logic                   opcodeLatch
);

  typedef enum logic [1:0] {afterReset, startFlow, runFlow, endFlow} seqState;
  seqState state;

  microcodePkg::uCmd uopCmd;
  logic running, isBus, advance, busActive, eofHit;

  assign uopCmd = microcodePkg::uCmd'(uop[13:10]);
  assign running = state == runFlow;
  assign isBus = uop[microcodePkg::busBit];
  assign advance = running && (!isBus || busDone);   // Bus ops stall here

  assign cmd = advance ? uopCmd : microcodePkg::cmdNop;
  assign operandSel = uop[4:0];
  assign pcStep = advance && uop[microcodePkg::incPcBit];
  assign busStart = running && isBus && !busActive;
  assign busWriteKind = uopCmd == microcodePkg::cmdWriteHigh;
  assign opcodeLatch = advance && uopCmd == microcodePkg::cmdDispatch;

  always_comb
  begin
    case (microcodePkg::eofCond'(uop[9:7]))
      microcodePkg::eofAlways: eofHit = 1'b1;
      microcodePkg::eofIfZ:    eofHit = flagsZ;
      microcodePkg::eofIfNZ:   eofHit = !flagsZ;
      microcodePkg::eofIfC:    eofHit = flagsC;
      microcodePkg::eofIfNC:   eofHit = !flagsC;
      default:                 eofHit = 1'b0;
    endcase
  end

  always_ff @(posedge iClock)
  begin
    if (reset)
    begin
      state <= afterReset;
      uPc <= microcodePkg::flowFetch;
      busActive <= 1'b0;
    end
    else
    begin
      if (busStart)
        busActive <= 1'b1;
      else if (busDone)
        busActive <= 1'b0;
      case (state)
        afterReset: state <= startFlow;
        startFlow:
        begin
          uPc <= intPending ? microcodePkg::flowInterrupt : microcodePkg::flowFetch;
          state <= runFlow;
        end
        runFlow:
          if (advance)
          begin
            if (eofHit)
              state <= endFlow;
            else if (uopCmd == microcodePkg::cmdDispatch)
              uPc <= opFlow;
            else
              uPc <= uPc + 6'd1;
          end
        default: state <= startFlow;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile
#(
  parameter logic [15:0] resetPc = 16'h0100
)
(
  input  wire logic             iClock,
  input  wire logic             reset,
  input  microcodePkg::uCmd     cmd,
  input  wire logic [4:0]       operandSel,
  input  wire logic             pcStep,
  input  wire logic             opcodeLatch,
  input  wire logic [7:0]       readData,
  input  wire logic [7:0]       aluResult,
  input  wire logic [7:0]       aluFlags,
  input  wire logic [15:0]      vector,
  output cpuIsaPkg::opcodeWord  opcode,
  output logic [7:0]            regA,
  output logic [7:0]            regSrc,
  output logic [7:0]            flags,
  output logic [15:0]           busAddr,
  output logic [7:0]            busWriteData
);

  logic [7:0]        regs [8];
  logic [15:0]       pc;
  logic [15:0]       tmp;
  cpuIsaPkg::regCode target;

  assign target = operandSel[4] ? opcode.f.dst : operandSel[2:0];
  assign regA = regs[cpuIsaPkg::regA];
  assign regSrc = regs[opcode.f.src];
  assign busAddr = operandSel[3] ? {cpuIsaPkg::highPage, tmp[7:0]} : pc;
  assign busWriteData = regs[cpuIsaPkg::regA];

  always_ff @(posedge iClock)
  begin
    if (reset)
    begin
      pc <= resetPc;
      flags <= cpuIsaPkg::flagsResetValue;
    end
    else
    begin
      if (cmd == microcodePkg::cmdJump)
        pc <= tmp;
      else if (cmd == microcodePkg::cmdIntJump)
        pc <= vector;
      else if (pcStep)
        pc <= pc + 16'd1;
      if (cmd == microcodePkg::cmdRegOp)
        flags <= aluFlags;
    end
  end

  always_ff @(posedge iClock)
  begin
    if (opcodeLatch)
      opcode <= readData;
    case (cmd)
      microcodePkg::cmdLoadReg: regs[target] <= readData;
      microcodePkg::cmdRegOp:   regs[target] <= aluResult;
      microcodePkg::cmdTmpLo:   tmp[7:0] <= readData;
      microcodePkg::cmdTmpHi:   tmp[15:8] <= readData;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- src/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
(
  input  cpuIsaPkg::opcodeWord  opcode,
  input  wire logic [7:0]       regA,
  input  wire logic [7:0]       regSrc,
  input  wire logic [7:0]       flagsIn,
  output logic [7:0]            result,
  output logic [7:0]            flagsOut
);

  cpuIsaPkg::aluOp op;
  logic [8:0]      wide;
  logic [4:0]      nibble;

  always_comb
  begin
    op = cpuIsaPkg::aluPass;
    if (opcode.f.group == 2'b10)
    begin
      case (opcode.f.dst)
        3'd0: op = cpuIsaPkg::aluAdd;
        3'd2: op = cpuIsaPkg::aluSub;
        3'd4: op = cpuIsaPkg::aluAnd;
        3'd5: op = cpuIsaPkg::aluXor;
        3'd6: op = cpuIsaPkg::aluOr;
        default: op = cpuIsaPkg::aluPass;
      endcase
    end

    wide = '0;
    nibble = '0;
    flagsOut = {flagsIn[7:4], 4'b0};
    case (op)
      cpuIsaPkg::aluAdd:
      begin
        wide = {1'b0, regA} + {1'b0, regSrc};
        nibble = {1'b0, regA[3:0]} + {1'b0, regSrc[3:0]};
      end
      cpuIsaPkg::aluSub:
      begin
        wide = {1'b0, regA} - {1'b0, regSrc};
        nibble = {1'b0, regA[3:0]} - {1'b0, regSrc[3:0]};   // Bit 4 is the half borrow
      end
      cpuIsaPkg::aluAnd: wide = {1'b0, regA & regSrc};
      cpuIsaPkg::aluXor: wide = {1'b0, regA ^ regSrc};
      cpuIsaPkg::aluOr:  wide = {1'b0, regA | regSrc};
      default:           wide = {1'b0, regSrc};
    endcase
    result = wide[7:0];

    if (op != cpuIsaPkg::aluPass)
    begin
      flagsOut[cpuIsaPkg::flagZ] = wide[7:0] == 8'h00;
      flagsOut[cpuIsaPkg::flagN] = op == cpuIsaPkg::aluSub;
      flagsOut[cpuIsaPkg::flagH] = (op == cpuIsaPkg::aluAnd) || nibble[4];
      flagsOut[cpuIsaPkg::flagC] = wide[8];
    end
  end

endmodule

`default_nettype wire

//--- src/gbMicroCpu.sv
`timescale 1ns/1ps
`default_nettype none

module gbMicroCpu
#(
  parameter logic [15:0] resetPc = 16'h0100
)
(
  input  wire logic        iClock,
  input  wire logic        reset,
  output logic             memReq,
  input  wire logic        memAck,
  output logic             memWrite,
  output logic [15:0]      memAddr,
  output logic [7:0]       memWriteData,
  input  wire logic [7:0]  memReadData,
  input  wire logic [3:0]  irq
);

  microcodePkg::flowIdx uPc, opFlow;
  microcodePkg::uopWord uop;
  microcodePkg::uCmd    cmd;
  cpuIsaPkg::opcodeWord opcode, fetchedOp;
  logic [4:0]  operandSel;
  logic        pcStep, busStart, busWriteKind, opcodeLatch, busDone, intPending;
  logic [7:0]  readData, regA, regSrc, flags, aluResult, aluFlags, busWriteData;
  logic [15:0] vector, busAddr;

  assign fetchedOp = readData;   // Opcode byte straight from the bus for dispatch

  // ----------------------------------------------------------------------
  busPort u_busPort (.iClock, .reset, .start(busStart), .writeKind(busWriteKind),
    .addr(busAddr), .writeData(busWriteData), .memReq, .memWrite, .memAddr,
    .memWriteData, .memAck, .memReadData, .busDone, .readData);

  interruptController u_interruptController (.iClock, .reset, .irq, .cmd, .intPending,
    .vector);

  microcodeRom u_microcodeRom (.uPc, .opcode(fetchedOp), .uop, .opFlow);

  microSequencer u_microSequencer (.iClock, .reset, .opFlow, .uop, .intPending, .busDone,
    .flagsZ(flags[cpuIsaPkg::flagZ]), .flagsC(flags[cpuIsaPkg::flagC]), .uPc, .cmd,
    .operandSel, .pcStep, .busStart, .busWriteKind, .opcodeLatch);

  registerFile #(.resetPc(resetPc)) u_registerFile (.iClock, .reset, .cmd, .operandSel,
    .pcStep, .opcodeLatch, .readData, .aluResult, .aluFlags, .vector, .opcode, .regA,
    .regSrc, .flags, .busAddr, .busWriteData);

  alu u_alu (.opcode, .regA, .regSrc, .flagsIn(flags), .result(aluResult),
    .flagsOut(aluFlags));

endmodule

`default_nettype wire

//--- sim/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen
(
  output logic iClock
);

  initial iClock = 1'b0;

  always #2 iClock = ~iClock;   // 4 ns period

endmodule

`default_nettype wire

//--- sim/tbGbMicroCpu.sv
`timescale 1ns/1ps
`default_nettype none

module tbGbMicroCpu;

  localparam logic [15:0] startPc = 16'h0100;
  localparam int waitLimit = 20000;
  localparam logic [2:0] aluKinds [5] = '{3'd0, 3'd2, 3'd4, 3'd5, 3'd6};

  logic        iClock;
  logic        reset = 1'b1;
  logic        memAck = 1'b0;
  logic [7:0]  memReadData = 8'h00;
  logic [3:0]  irq = 4'b0000;
  logic        memReq;
  logic        memWrite;
  logic [15:0] memAddr;
  logic [7:0]  memWriteData;

  logic [7:0]  mem [65536];
  logic [24:0] trace [1024];   // {write, addr, data} per bus transfer
  logic [9:0]  traceLen = '0;
  logic [9:0]  traceIdx = '0;
  logic        reqLast = 1'b0;
  logic [2:0]  ackDelay = 3'd0;
  logic [24:0] expHead;
  logic        expLive, expWrite;
  logic [15:0] expAddr;
  logic [7:0]  expData;
  int          errorCount = 0;
  int          timeoutCount = 0;

  // Reference model state
  logic [7:0]  model [8];
  logic        zModel, cModel;
  logic [15:0] cursor, marker1, marker2;

  clockGen u_clockGen (.iClock);

  gbMicroCpu #(.resetPc(startPc)) u_gbMicroCpu (.iClock, .reset, .memReq, .memAck,
    .memWrite, .memAddr, .memWriteData, .memReadData, .irq);

  // ----------------------------------------------------------------------
  // Memory with a random delay of 0 to 5 cycles on each ack edge
  always @(posedge iClock)
  begin
    if (reset)
    begin
      memAck <= 1'b0;
      ackDelay <= 3'd0;
    end
    else if (memReq != memAck)
    begin
      if (ackDelay == 3'd0)
      begin
        memAck <= memReq;
        if (memReq)
          memReadData <= memWrite ? 8'h00 : mem[memAddr];
        ackDelay <= 3'($urandom % 6);
      end
      else
        ackDelay <= ackDelay - 3'd1;
    end
  end

  // One trace entry used per rising memReq
  always @(posedge iClock)
  begin
    reqLast <= memReq;
    if (memReq && !reqLast && traceIdx < traceLen)
      traceIdx <= traceIdx + 10'd1;
  end

  assign expHead = trace[traceIdx];
  assign expLive = traceIdx < traceLen;
  assign expWrite = expHead[24];
  assign expAddr = expHead[23:8];
  assign expData = expHead[7:0];

  // ----------------------------------------------------------------------
  // Checks
  resetQuiet: assert property (@(posedge iClock) $past(reset) |-> !memReq && !memWrite)
  else
  begin
    errorCount++;
    $display("Error: memReq=%h memWrite=%h after reset, expected 0 and 0",
      $sampled(memReq), $sampled(memWrite));
  end

  reqRise: assert property (@(posedge iClock) disable iff (reset) $rose(memReq) |-> !memAck)
  else
  begin
    errorCount++;
    $display("memReq rose while memAck was still high");
  end

  reqStable: assert property (@(posedge iClock) disable iff (reset)
      memReq && $past(memReq) |-> $stable(memAddr) && $stable(memWrite) && $stable(memWriteData))
  else
  begin
    errorCount++;
    $display("Error: memAddr=%h memWrite=%h memWriteData=%h changed while memReq was high",
      $sampled(memAddr), $sampled(memWrite), $sampled(memWriteData));
  end

  reqDrop: assert property (@(posedge iClock) disable iff (reset) memReq && memAck |=> !memReq)
  else
  begin
    errorCount++;
    $display("memReq stayed high for more than one cycle after memAck");
  end

  addrCheck: assert property (@(posedge iClock) disable iff (reset)
      $rose(memReq) && expLive |-> memAddr == expAddr)
  else
  begin
    errorCount++;
    $display("Error: memAddr=%h, expected %h", $sampled(memAddr), $sampled(expAddr));
  end

  kindCheck: assert property (@(posedge iClock) disable iff (reset)
      $rose(memReq) && expLive |-> memWrite == expWrite)
  else
  begin
    errorCount++;
    $display("Error: memWrite=%h at %h, expected %h", $sampled(memWrite), $sampled(memAddr),
      $sampled(expWrite));
  end

  dataCheck: assert property (@(posedge iClock) disable iff (reset)
      $rose(memReq) && expLive && expWrite |-> memWriteData == expData)
  else
  begin
    errorCount++;
    $display("Error: memWriteData=%h, expected %h", $sampled(memWriteData), $sampled(expData));
  end

  // ----------------------------------------------------------------------
  // Program builder and reference model
  task automatic placeByte(input logic [7:0] value);
    mem[cursor] = value;
    cursor = cursor + 16'd1;
  endtask

  task automatic fetchByte(input logic [7:0] value);
    trace[traceLen] = {1'b0, cursor, 8'h00};
    traceLen = traceLen + 10'd1;
    placeByte(value);
  endtask

  task automatic noteWrite(input logic [15:0] addr, input logic [7:0] data);
    trace[traceLen] = {1'b1, addr, data};
    traceLen = traceLen + 10'd1;
  endtask

  task automatic loadImmediate(input logic [2:0] r, input logic [7:0] n);
    fetchByte({2'b00, r, 3'd6});
    fetchByte(n);
    model[r] = n;
  endtask

  task automatic copyRegister(input logic [2:0] d, input logic [2:0] s);
    fetchByte({2'b01, d, s});
    model[d] = model[s];
  endtask

  task automatic storeHigh(input logic [7:0] n);
    fetchByte(8'hE0);
    fetchByte(n);
    noteWrite({8'hFF, n}, model[7]);
  endtask

  task automatic applyAlu(input logic [2:0] kind, input logic [2:0] s);
    logic [8:0] sum;
    logic [7:0] a, b, res;
    logic       carry;
    a = model[7];
    b = model[s];
    sum = {1'b0, a} + {1'b0, b};
    carry = 1'b0;
    fetchByte({2'b10, kind, s});
    case (kind)
      3'd0:
      begin
        res = sum[7:0];
        carry = sum[8];
      end
      3'd2:
      begin
        res = a - b;
        carry = a < b;   // Borrow
      end
      3'd4: res = a & b;
      3'd5: res = a ^ b;
      default: res = a | b;
    endcase
    model[7] = res;
    zModel = res == 8'h00;
    cModel = carry;
  endtask

  // JP cc over the NOP that follows it
  task automatic skipIf(input logic [1:0] cc);
    logic        taken;
    logic [15:0] target;
    case (cc)
      2'd0: taken = !zModel;
      2'd1: taken = zModel;
      2'd2: taken = !cModel;
      default: taken = cModel;
    endcase
    target = cursor + 16'd4;
    fetchByte({3'b110, cc, 3'b010});
    fetchByte(target[7:0]);
    fetchByte(target[15:8]);
    if (taken)
      placeByte(8'h00);
    else
      fetchByte(8'h00);
  endtask

  task automatic jumpTo(input logic [15:0] nn);
    fetchByte(8'hC3);
    fetchByte(nn[7:0]);
    fetchByte(nn[15:8]);
    cursor = nn;
  endtask

  // EI with a request already latched, so the vector comes next
  task automatic enableInts(input logic [15:0] vector);
    fetchByte(8'hFB);
    cursor = vector;
  endtask

  task automatic awaitFetch(input logic [15:0] addr, output logic ok);
    int cycles;
    cycles = 0;
    ok = 1'b0;
    while (!ok && cycles < waitLimit)
    begin
      @(posedge iClock);
      ok = memReq && !memWrite && memAddr == addr;
      cycles++;
    end
    if (!ok)
      $display("Timed out waiting for a fetch from address %h", addr);
  endtask

  task automatic awaitTrace(output logic ok);
    int cycles;
    cycles = 0;
    while (traceIdx < traceLen && cycles < waitLimit)
    begin
      @(posedge iClock);
      cycles++;
    end
    ok = traceIdx >= traceLen;
    if (!ok)
      $display("Timed out with %0d bus transfers still expected", traceLen - traceIdx);
  endtask

  // ----------------------------------------------------------------------
  initial
  begin
    int         i, r, round, k;
    logic       ok;
    logic [2:0] s;
    logic [7:0] n1;
    void'($urandom(32'h3c5b));
    for (i = 0; i < 65536; i++)
      mem[i] = i[15:8] ^ i[7:0];
    cursor = startPc;
    zModel = 1'b1;   // Flags reset to B0
    cModel = 1'b1;

    skipIf(2'd1);
    fetchByte(8'hFB);   // EI with nothing latched
    fetchByte(8'hF3);   // DI
    for (r = 0; r < 6; r++)
      loadImmediate(3'(r), 8'($urandom));
    for (r = 0; r < 6; r++)
    begin
      copyRegister(3'd7, 3'(r));
      storeHigh(8'($urandom));
    end
    copyRegister(3'd5, 3'd1);
    copyRegister(3'd7, 3'd5);
    storeHigh(8'($urandom));
    loadImmediate(3'd7, 8'($urandom));
    storeHigh(8'($urandom));
    skipIf(2'd3);

    for (round = 0; round < 3; round++)
      for (k = 0; k < 5; k++)
      begin
        n1 = 8'($urandom);
        loadImmediate(3'd7, n1);
        s = 3'($urandom % 7);
        if (s == 3'd6)
          s = 3'd7;
        if (s != 3'd7)
          loadImmediate(s, ($urandom % 4 == 0) ? n1 : 8'($urandom));   // Equal operands now and then
        applyAlu(aluKinds[k], s);
        storeHigh(8'($urandom));
        skipIf({1'b0, 1'($urandom)});
        skipIf({1'b1, 1'($urandom)});
      end

    marker1 = cursor;
    repeat (3) fetchByte(8'h00);
    jumpTo(16'h0280);
    fetchByte(8'h00);
    enableInts(16'h0048);   // Bits 1 and 2 latched
    jumpTo(16'h0300);
    marker2 = cursor;
    repeat (3) fetchByte(8'h00);
    enableInts(16'h0040);
    fetchByte(8'h00);
    jumpTo(cursor);   // Spin here

    repeat (16) @(posedge iClock);
    reset <= 1'b0;
    awaitFetch(marker1, ok);
    if (ok)
    begin
      irq <= 4'b0110;
      @(posedge iClock);
      irq <= 4'b0000;
      awaitFetch(marker2, ok);
    end
    if (ok)
    begin
      irq <= 4'b0001;
      @(posedge iClock);
      irq <= 4'b0000;
      awaitTrace(ok);
    end
    if (!ok)
      timeoutCount++;
    repeat (4) @(posedge iClock);
    $display("Failed checks: %0d, timeouts: %0d", errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- gbMicroCpu.f
src/cpuIsaPkg.sv
src/microcodePkg.sv
src/busPort.sv
src/interruptController.sv
src/microcodeRom.sv
src/microSequencer.sv
src/registerFile.sv
src/alu.sv
src/gbMicroCpu.sv
sim/clockGen.sv
sim/tbGbMicroCpu.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tbGbMicroCpu -f gbMicroCpu.f \
  -o simGbMicroCpu
output=$(./obj_dir/simGbMicroCpu)
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qx "Simulation completed successfully"; then
  exit 0
fi
exit 1
